// ==== Bender.yml ====
package:
  name: riscv_core

sources:
  - src/core_pkg.sv
  - src/pipe_reg.sv
  - src/decode_unit.sv
  - src/register_file.sv
  - src/alu.sv
  - src/execute_stage.sv
  - src/hazard_unit.sv
  - src/riscv_core.sv
  - target: test
    files:
      - testbench/core_tb_sva.sv
      - testbench/core_tb.sv

// ==== src/alu.sv ====
`timescale 1ns/10ps

module alu
    import core_pkg::*;
(
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    input  alu_op_e         op,
    output logic [xlen-1:0] result,
    output logic            zero
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            alu_add:  result = a + b;
            alu_sub:  result = a - b;
            alu_and:  result = a & b;
            alu_or:   result = a | b;
            alu_xor:  result = a ^ b;
            alu_sll:  result = a << shamt;
            alu_srl:  result = a >> shamt;
            alu_sra:  result = $signed(a) >>> shamt;
            alu_slt:  result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            alu_sltu: result = {{(xlen-1){1'b0}}, a < b};
            default:  result = '0;
        endcase
    end

    // Branch compare relies on this after a subtract
    assign zero = (result == '0);

endmodule

// ==== src/core_pkg.sv ====
package core_pkg;

    // Widths
    localparam int xlen          = 32;
    localparam int reg_addr_bits = 5;

    // addi x0, x0, 0
    localparam logic [xlen-1:0] nop_instr = 32'h0000_0013;

    // Major opcodes
    localparam logic [6:0] opcode_op     = 7'b0110011;
    localparam logic [6:0] opcode_op_imm = 7'b0010011;
    localparam logic [6:0] opcode_load   = 7'b0000011;
    localparam logic [6:0] opcode_store  = 7'b0100011;
    localparam logic [6:0] opcode_branch = 7'b1100011;

    // funct3 for OP and OP-IMM
    localparam logic [2:0] funct3_add  = 3'b000;
    localparam logic [2:0] funct3_sll  = 3'b001;
    localparam logic [2:0] funct3_slt  = 3'b010;
    localparam logic [2:0] funct3_sltu = 3'b011;
    localparam logic [2:0] funct3_xor  = 3'b100;
    localparam logic [2:0] funct3_sr   = 3'b101;
    localparam logic [2:0] funct3_or   = 3'b110;
    localparam logic [2:0] funct3_and  = 3'b111;

    // funct3 for branches
    localparam logic [2:0] funct3_beq = 3'b000;
    localparam logic [2:0] funct3_bne = 3'b001;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_slt,
        alu_sltu
    } alu_op_e;

    typedef enum logic [1:0] {
        from_reg,
        from_mem,
        from_wb
    } fwd_sel_e;

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    mem_to_reg;
        logic    alu_src_imm;
        logic    branch;
        logic    branch_ne;
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] instr;
    } if_id_t;

    typedef struct packed {
        logic                     valid;
        ctrl_t                    ctrl;
        logic [xlen-1:0]          pc;
        logic [xlen-1:0]          rs1_data;
        logic [xlen-1:0]          rs2_data;
        logic [reg_addr_bits-1:0] rs1;
        logic [reg_addr_bits-1:0] rs2;
        logic [reg_addr_bits-1:0] rd;
        logic [xlen-1:0]          imm;
    } id_ex_t;

    typedef struct packed {
        logic                     valid;
        logic                     reg_write;
        logic                     mem_read;
        logic                     mem_write;
        logic                     mem_to_reg;
        logic [xlen-1:0]          alu_result;
        logic [xlen-1:0]          store_data;
        logic [reg_addr_bits-1:0] rd;
    } ex_mem_t;

    typedef struct packed {
        logic                     valid;
        logic                     reg_write;
        logic                     mem_to_reg;
        logic [xlen-1:0]          alu_result;
        logic [xlen-1:0]          load_data;
        logic [reg_addr_bits-1:0] rd;
    } mem_wb_t;

    // Data port request, word access only
    typedef struct packed {
        logic            read;
        logic            write;
        logic [xlen-1:0] addr;
        logic [xlen-1:0] wdata;
    } dmem_req_t;

endpackage

// ==== src/decode_unit.sv ====
`timescale 1ns/10ps

module decode_unit
    import core_pkg::*;
(
    input  logic [xlen-1:0]          instr,
    output ctrl_t                    ctrl,
    output logic [xlen-1:0]          imm,
    output logic [reg_addr_bits-1:0] rs1,
    output logic [reg_addr_bits-1:0] rs2,
    output logic [reg_addr_bits-1:0] rd
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic            funct7_alt;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_b;
    alu_op_e         arith_op;

    assign opcode     = instr[6:0];
    assign funct3     = instr[14:12];
    assign funct7_alt = instr[30];
    assign rd         = instr[11:7];
    assign rs1        = instr[19:15];
    assign rs2        = instr[24:20];

    // Sign-extended immediates
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

    // ALU operation for OP and OP-IMM, sub only exists in OP
    always_comb begin
        case (funct3)
            funct3_add:  arith_op = (opcode == opcode_op && funct7_alt) ? alu_sub : alu_add;
            funct3_sll:  arith_op = alu_sll;
            funct3_slt:  arith_op = alu_slt;
            funct3_sltu: arith_op = alu_sltu;
            funct3_xor:  arith_op = alu_xor;
            funct3_sr:   arith_op = funct7_alt ? alu_sra : alu_srl;
            funct3_or:   arith_op = alu_or;
            default:     arith_op = alu_and;
        endcase
    end

    always_comb begin
        ctrl = '0;
        imm  = '0;
        case (opcode)
            opcode_op: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = arith_op;
            end
            opcode_op_imm: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = arith_op;
                imm              = imm_i;
            end
            opcode_load: begin
                ctrl.reg_write   = 1'b1;
                ctrl.mem_read    = 1'b1;
                ctrl.mem_to_reg  = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                imm              = imm_i;
            end
            opcode_store: begin
                ctrl.mem_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                imm              = imm_s;
            end
            opcode_branch: begin
                // Only beq and bne, anything else stays a no-op
                if (funct3 == funct3_beq || funct3 == funct3_bne) begin
                    ctrl.branch    = 1'b1;
                    ctrl.branch_ne = (funct3 == funct3_bne);
                    ctrl.alu_op    = alu_sub;
                    imm            = imm_b;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== src/execute_stage.sv ====
`timescale 1ns/10ps

module execute_stage
    import core_pkg::*;
(
    input  id_ex_t          id_ex,
    input  fwd_sel_e        fwd_a,
    input  fwd_sel_e        fwd_b,
    input  logic [xlen-1:0] mem_result,
    input  logic [xlen-1:0] wb_result,
    output ex_mem_t         ex_mem_d,
    output logic            branch_taken,
    output logic [xlen-1:0] branch_target
);

    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b_reg;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] alu_result;
    logic            alu_zero;

    // Forwarding muxes
    always_comb begin
        case (fwd_a)
            from_mem: op_a = mem_result;
            from_wb:  op_a = wb_result;
            default:  op_a = id_ex.rs1_data;
        endcase
        case (fwd_b)
            from_mem: op_b_reg = mem_result;
            from_wb:  op_b_reg = wb_result;
            default:  op_b_reg = id_ex.rs2_data;
        endcase
    end

    assign op_b = id_ex.ctrl.alu_src_imm ? id_ex.imm : op_b_reg;

    alu alu0 (
        .a      (op_a),
        .b      (op_b),
        .op     (id_ex.ctrl.alu_op),
        .result (alu_result),
        .zero   (alu_zero)
    );

    // beq takes on equal, bne on not equal
    assign branch_target = id_ex.pc + id_ex.imm;
    assign branch_taken  = id_ex.valid && id_ex.ctrl.branch
                           && (alu_zero ^ id_ex.ctrl.branch_ne);

    always_comb begin
        ex_mem_d.valid      = id_ex.valid;
        ex_mem_d.reg_write  = id_ex.ctrl.reg_write;
        ex_mem_d.mem_read   = id_ex.ctrl.mem_read;
        ex_mem_d.mem_write  = id_ex.ctrl.mem_write;
        ex_mem_d.mem_to_reg = id_ex.ctrl.mem_to_reg;
        ex_mem_d.alu_result = alu_result;
        ex_mem_d.store_data = op_b_reg;
        ex_mem_d.rd         = id_ex.rd;
    end

endmodule

// ==== src/hazard_unit.sv ====
`timescale 1ns/10ps

module hazard_unit
    import core_pkg::*;
(
    input  logic [reg_addr_bits-1:0] if_id_rs1,
    input  logic [reg_addr_bits-1:0] if_id_rs2,
    input  id_ex_t                   id_ex,
    input  ex_mem_t                  ex_mem,
    input  mem_wb_t                  mem_wb,
    input  logic                     branch_taken,
    output logic                     stall,
    output logic                     flush,
    output fwd_sel_e                 fwd_a,
    output fwd_sel_e                 fwd_b
);

    logic mem_writes;
    logic wb_writes;
    logic load_use;

    // Only a real writer to a non-zero register can forward
    assign mem_writes = ex_mem.valid && ex_mem.reg_write && ex_mem.rd != '0;
    assign wb_writes  = mem_wb.valid && mem_wb.reg_write && mem_wb.rd != '0;

    // MEM is younger than WB so it wins
    always_comb begin
        if (mem_writes && ex_mem.rd == id_ex.rs1) begin
            fwd_a = from_mem;
        end else if (wb_writes && mem_wb.rd == id_ex.rs1) begin
            fwd_a = from_wb;
        end else begin
            fwd_a = from_reg;
        end
        if (mem_writes && ex_mem.rd == id_ex.rs2) begin
            fwd_b = from_mem;
        end else if (wb_writes && mem_wb.rd == id_ex.rs2) begin
            fwd_b = from_wb;
        end else begin
            fwd_b = from_reg;
        end
    end

    // Load result is not ready until WB
    assign load_use = id_ex.valid && id_ex.ctrl.mem_read && id_ex.rd != '0
                      && (id_ex.rd == if_id_rs1 || id_ex.rd == if_id_rs2);

    // A taken branch kills the dependent instruction anyway
    assign flush = branch_taken;
    assign stall = load_use && !branch_taken;

endmodule

// ==== src/pipe_reg.sv ====
`timescale 1ns/10ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     stall,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    // An all-zero payload is a bubble with valid low
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            q <= '0;
        end else if (!stall) begin
            q <= d;
        end
    end

endmodule

// ==== src/register_file.sv ====
`timescale 1ns/10ps

module register_file
    import core_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic [reg_addr_bits-1:0] rs1,
    input  logic [reg_addr_bits-1:0] rs2,
    input  logic [reg_addr_bits-1:0] rd,
    input  logic [xlen-1:0]          wdata,
    input  logic                     we,
    output logic [xlen-1:0]          rs1_data,
    output logic [xlen-1:0]          rs2_data
);

    logic [xlen-1:0] regs [2**reg_addr_bits];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2**reg_addr_bits; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    // Writeback in the same cycle is seen by decode
    always_comb begin
        rs1_data = (we && rd == rs1) ? wdata : regs[rs1];
        rs2_data = (we && rd == rs2) ? wdata : regs[rs2];
        if (rs1 == '0) begin
            rs1_data = '0;
        end
        if (rs2 == '0) begin
            rs2_data = '0;
        end
    end

endmodule

// ==== src/riscv_core.sv ====
`timescale 1ns/10ps

module riscv_core
    import core_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    output logic [xlen-1:0] imem_addr,
    input  logic [xlen-1:0] imem_rdata,
    output dmem_req_t       dmem_req,
    input  logic [xlen-1:0] dmem_rdata
);

    logic [xlen-1:0]          pc;
    logic [xlen-1:0]          pc_plus4;
    logic [xlen-1:0]          id_instr;
    logic [xlen-1:0]          rs1_data;
    logic [xlen-1:0]          rs2_data;
    logic [xlen-1:0]          imm;
    logic [xlen-1:0]          wb_data;
    logic [xlen-1:0]          branch_target;
    logic [reg_addr_bits-1:0] rs1;
    logic [reg_addr_bits-1:0] rs2;
    logic [reg_addr_bits-1:0] rd;
    logic                     stall;
    logic                     flush;
    logic                     branch_taken;
    ctrl_t                    ctrl;
    fwd_sel_e                 fwd_a;
    fwd_sel_e                 fwd_b;
    if_id_t                   if_id_d, if_id_q;
    id_ex_t                   id_ex_d, id_ex_q;
    ex_mem_t                  ex_mem_d, ex_mem_q;
    mem_wb_t                  mem_wb_d, mem_wb_q;

    // Fetch
    assign pc_plus4  = pc + xlen'(4);
    assign imem_addr = pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (branch_taken) begin
            pc <= branch_target;
        end else if (!stall) begin
            pc <= pc_plus4;
        end
    end

    assign if_id_d = '{valid: 1'b1, pc: pc, instr: imem_rdata};

    pipe_reg #(.payload_t(if_id_t)) if_id_reg (
        .clk   (clk),
        .reset (reset),
        .stall (stall),
        .flush (flush),
        .d     (if_id_d),
        .q     (if_id_q)
    );

    // Decode, a bubble decodes as a plain nop
    assign id_instr = if_id_q.valid ? if_id_q.instr : nop_instr;

    decode_unit decoder (
        .instr (id_instr),
        .ctrl  (ctrl),
        .imm   (imm),
        .rs1   (rs1),
        .rs2   (rs2),
        .rd    (rd)
    );

    register_file regfile (
        .clk      (clk),
        .reset    (reset),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (mem_wb_q.rd),
        .wdata    (wb_data),
        .we       (mem_wb_q.valid && mem_wb_q.reg_write),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    always_comb begin
        id_ex_d.valid    = if_id_q.valid;
        id_ex_d.ctrl     = ctrl;
        id_ex_d.pc       = if_id_q.pc;
        id_ex_d.rs1_data = rs1_data;
        id_ex_d.rs2_data = rs2_data;
        id_ex_d.rs1      = rs1;
        id_ex_d.rs2      = rs2;
        id_ex_d.rd       = rd;
        id_ex_d.imm      = imm;
    end

    // Stall leaves a bubble behind the held instruction
    pipe_reg #(.payload_t(id_ex_t)) id_ex_reg (
        .clk   (clk),
        .reset (reset),
        .stall (1'b0),
        .flush (flush || stall),
        .d     (id_ex_d),
        .q     (id_ex_q)
    );

    execute_stage ex_stage (
        .id_ex         (id_ex_q),
        .fwd_a         (fwd_a),
        .fwd_b         (fwd_b),
        .mem_result    (ex_mem_q.alu_result),
        .wb_result     (wb_data),
        .ex_mem_d      (ex_mem_d),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    pipe_reg #(.payload_t(ex_mem_t)) ex_mem_reg (
        .clk   (clk),
        .reset (reset),
        .stall (1'b0),
        .flush (1'b0),
        .d     (ex_mem_d),
        .q     (ex_mem_q)
    );

    // Data port straight from EX/MEM
    assign dmem_req.read  = ex_mem_q.valid && ex_mem_q.mem_read;
    assign dmem_req.write = ex_mem_q.valid && ex_mem_q.mem_write;
    assign dmem_req.addr  = ex_mem_q.alu_result;
    assign dmem_req.wdata = ex_mem_q.store_data;

    always_comb begin
        mem_wb_d.valid      = ex_mem_q.valid;
        mem_wb_d.reg_write  = ex_mem_q.reg_write;
        mem_wb_d.mem_to_reg = ex_mem_q.mem_to_reg;
        mem_wb_d.alu_result = ex_mem_q.alu_result;
        mem_wb_d.load_data  = dmem_rdata;
        mem_wb_d.rd         = ex_mem_q.rd;
    end

    pipe_reg #(.payload_t(mem_wb_t)) mem_wb_reg (
        .clk   (clk),
        .reset (reset),
        .stall (1'b0),
        .flush (1'b0),
        .d     (mem_wb_d),
        .q     (mem_wb_q)
    );

    // Writeback select
    assign wb_data = mem_wb_q.mem_to_reg ? mem_wb_q.load_data : mem_wb_q.alu_result;

    hazard_unit hazards (
        .if_id_rs1    (rs1),
        .if_id_rs2    (rs2),
        .id_ex        (id_ex_q),
        .ex_mem       (ex_mem_q),
        .mem_wb       (mem_wb_q),
        .branch_taken (branch_taken),
        .stall        (stall),
        .flush        (flush),
        .fwd_a        (fwd_a),
        .fwd_b        (fwd_b)
    );

endmodule

// ==== testbench/core_tb.sv ====
`timescale 1ns/10ps

module core_tb
    import core_pkg::*;
();

    logic            clk;
    logic            reset;
    logic [xlen-1:0] imem_addr;
    logic [xlen-1:0] imem_rdata;
    logic [xlen-1:0] dmem_rdata;
    dmem_req_t       dmem_req;

    logic [xlen-1:0] imem [256];
    logic [xlen-1:0] dmem [256];
    logic [xlen-1:0] progs [3][256];
    int              prog_len [3];
    int              build_index;
    logic [15:0]     lfsr;
    logic [xlen-1:0] exp_addr_q [$];
    logic [xlen-1:0] exp_data_q [$];
    int              value_errors;
    int              trace_errors;
    int              other_errors;
    int              cycle_limit;

    riscv_core dut0 (
        .clk        (clk),
        .reset      (reset),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata)
    );

    // Both memories answer in the same cycle, data only under the read strobe
    assign imem_rdata = imem[imem_addr[9:2]];
    assign dmem_rdata = dmem_req.read ? dmem[dmem_req.addr[9:2]] : 'x;

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    function automatic logic [31:0] fill_word(input int i);
        return 32'h5a00_0000 ^ (32'(i) * 32'h0001_0203);
    endfunction

    // Instruction encoders
    function automatic logic [31:0] r_type(input int f3, input int alt, input int rd,
                                           input int rs1, input int rs2);
        return {(alt != 0) ? 7'h20 : 7'h00, 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), opcode_op};
    endfunction

    function automatic logic [31:0] i_type(input logic [6:0] opc, input int f3, input int rd,
                                           input int rs1, input int imm);
        return {12'(imm), 5'(rs1), 3'(f3), 5'(rd), opc};
    endfunction

    function automatic logic [31:0] sw(input int rs2, input int rs1, input int imm);
        logic [11:0] i;
        i = 12'(imm);
        return {i[11:5], 5'(rs2), 5'(rs1), 3'b010, i[4:0], opcode_store};
    endfunction

    function automatic logic [31:0] b_type(input int f3, input int rs1, input int rs2,
                                           input int imm);
        logic [12:0] i;
        i = 13'(imm);
        return {i[12], i[10:5], 5'(rs2), 5'(rs1), 3'(f3), i[4:1], i[11], opcode_branch};
    endfunction

    function automatic logic [31:0] addi(input int rd, input int rs1, input int imm);
        return i_type(opcode_op_imm, funct3_add, rd, rs1, imm);
    endfunction

    function automatic void emit(input logic [31:0] w);
        progs[build_index][prog_len[build_index]] = w;
        prog_len[build_index]++;
    endfunction

    function automatic void store_regs(input int first, input int last, input int base);
        for (int r = first; r <= last; r++) begin
            emit(sw(r, 0, base + 4 * (r - first)));
        end
    endfunction

    // 16-bit Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    function automatic logic [31:0] random_alu_instr();
        int rd;
        int rs1;
        int rs2;
        rd  = rand_bits(4);
        rs1 = rand_bits(4);
        rs2 = rand_bits(4);
        if (rand_bits(1) == 1) begin
            case (rand_bits(3) % 5)
                0:       return i_type(opcode_op_imm, funct3_add, rd, rs1, rand_bits(12));
                1:       return i_type(opcode_op_imm, funct3_and, rd, rs1, rand_bits(12));
                2:       return i_type(opcode_op_imm, funct3_or, rd, rs1, rand_bits(12));
                3:       return i_type(opcode_op_imm, funct3_xor, rd, rs1, rand_bits(12));
                default: return i_type(opcode_op_imm, funct3_slt, rd, rs1, rand_bits(12));
            endcase
        end
        case (rand_bits(4) % 10)
            0:       return r_type(funct3_add, 0, rd, rs1, rs2);
            1:       return r_type(funct3_add, 1, rd, rs1, rs2);
            2:       return r_type(funct3_and, 0, rd, rs1, rs2);
            3:       return r_type(funct3_or, 0, rd, rs1, rs2);
            4:       return r_type(funct3_xor, 0, rd, rs1, rs2);
            5:       return r_type(funct3_sll, 0, rd, rs1, rs2);
            6:       return r_type(funct3_sr, 0, rd, rs1, rs2);
            7:       return r_type(funct3_sr, 1, rd, rs1, rs2);
            8:       return r_type(funct3_slt, 0, rd, rs1, rs2);
            default: return r_type(funct3_sltu, 0, rd, rs1, rs2);
        endcase
    endfunction

    task automatic build_programs();
        logic [31:0] w;
        for (int p = 0; p < $size(prog_len); p++) begin
            prog_len[p] = 0;
        end
        // ALU results, dependency distances 1 to 3, x0 as destination
        build_index = 0;
        emit(addi(1, 0, 5));
        emit(addi(2, 0, -3));
        emit(r_type(funct3_add, 0, 3, 1, 2));
        emit(sw(3, 0, 0));
        emit(r_type(funct3_add, 1, 4, 3, 1));
        emit(r_type(funct3_and, 0, 5, 1, 2));
        emit(r_type(funct3_or, 0, 6, 4, 5));
        emit(r_type(funct3_xor, 0, 7, 1, 2));
        emit(r_type(funct3_sll, 0, 8, 1, 1));
        emit(r_type(funct3_sr, 0, 9, 2, 1));
        emit(r_type(funct3_sr, 1, 10, 2, 1));
        emit(r_type(funct3_slt, 0, 11, 2, 1));
        emit(r_type(funct3_sltu, 0, 12, 2, 1));
        emit(i_type(opcode_op_imm, funct3_and, 13, 2, 'h0f0));
        emit(i_type(opcode_op_imm, funct3_or, 14, 1, -256));
        emit(i_type(opcode_op_imm, funct3_xor, 15, 2, 'h555));
        emit(i_type(opcode_op_imm, funct3_slt, 16, 2, -2));
        emit(addi(0, 1, 7));
        // x0 read right behind its writer
        emit(sw(0, 0, 80));
        emit(addi(17, 1, 100));
        emit(addi(20, 0, 1));
        emit(addi(21, 0, 2));
        emit(sw(17, 0, 4));
        store_regs(0, 16, 8);
        emit(b_type(funct3_beq, 0, 0, 0));
        // Load-use and branches
        build_index = 1;
        emit(addi(1, 0, 40));
        emit(addi(2, 0, 77));
        emit(sw(2, 1, 0));
        emit(i_type(opcode_load, 3'b010, 3, 1, 0));
        emit(r_type(funct3_add, 0, 4, 3, 1));
        emit(sw(4, 1, 4));
        emit(i_type(opcode_load, 3'b010, 5, 1, 12));
        emit(sw(5, 1, 8));
        emit(b_type(funct3_beq, 1, 1, 12));
        emit(sw(1, 0, 0));
        emit(sw(2, 0, 4));
        emit(b_type(funct3_bne, 1, 2, 12));
        emit(sw(1, 0, 8));
        emit(sw(2, 0, 12));
        emit(b_type(funct3_beq, 1, 2, 8));
        emit(sw(1, 0, 16));
        emit(b_type(funct3_bne, 1, 1, 8));
        emit(sw(2, 0, 20));
        emit(b_type(funct3_beq, 0, 0, 0));
        // Random ALU mix with a store after every eighth instruction
        build_index = 2;
        for (int i = 0; i < 64; i++) begin
            w = random_alu_instr();
            emit(w);
            if (i % 8 == 7) begin
                emit(sw(w[11:7], 0, 128 + 4 * (i / 8)));
            end
        end
        store_regs(1, 15, 192);
        emit(b_type(funct3_beq, 0, 0, 0));
    endtask

    function automatic logic [31:0] exec_arith(input logic [2:0] f3, input logic alt,
                                               input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // Sequential model of the program, fills the expected store trace
    function automatic void run_reference(input int p);
        logic [31:0] regs [32];
        logic [31:0] mem [256];
        logic [31:0] pc;
        logic [31:0] next_pc;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] addr;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [4:0]  rd;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            mem[i] = fill_word(i);
        end
        pc = '0;
        for (int step = 0; step < 4096; step++) begin
            ins     = progs[p][pc[9:2]];
            rd      = ins[11:7];
            a       = regs[ins[19:15]];
            b       = regs[ins[24:20]];
            imm_i   = {{20{ins[31]}}, ins[31:20]};
            imm_s   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            imm_b   = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            next_pc = pc + 32'd4;
            case (ins[6:0])
                opcode_op: regs[rd] = exec_arith(ins[14:12], ins[30], a, b);
                opcode_op_imm: begin
                    regs[rd] = exec_arith(ins[14:12], ins[14:12] == 3'd5 && ins[30], a, imm_i);
                end
                opcode_load: begin
                    addr     = a + imm_i;
                    regs[rd] = mem[addr[9:2]];
                end
                opcode_store: begin
                    addr           = a + imm_s;
                    mem[addr[9:2]] = b;
                    exp_addr_q.push_back(addr);
                    exp_data_q.push_back(b);
                end
                opcode_branch: begin
                    if ((a == b) != ins[12]) begin
                        // Self-loop marks the end of the program
                        if (imm_b == '0) begin
                            return;
                        end
                        next_pc = pc + imm_b;
                    end
                end
                default: begin
                end
            endcase
            regs[0] = '0;
            pc = next_pc;
        end
    endfunction

    task automatic check_store(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] exp_addr;
        logic [31:0] exp_data;
        assert (exp_addr_q.size() > 0) else begin
            $display("Extra store to address %h with data %h not in the reference trace",
                     addr, data);
            trace_errors++;
        end
        if (exp_addr_q.size() > 0) begin
            exp_addr = exp_addr_q.pop_front();
            exp_data = exp_data_q.pop_front();
            assert (addr == exp_addr) else begin
                $display("[FAIL] dmem_req.addr: expected %h, got %h", exp_addr, addr);
                value_errors++;
            end
            assert (data == exp_data) else begin
                $display("[FAIL] dmem_req.wdata: expected %h, got %h", exp_data, data);
                value_errors++;
            end
        end
    endtask

    // Data memory write and store trace comparison
    always @(posedge clk) begin
        if (!reset && dmem_req.write) begin
            dmem[dmem_req.addr[9:2]] <= dmem_req.wdata;
            check_store(dmem_req.addr, dmem_req.wdata);
        end
    end

    // PC circles through the self-loop and the two slots behind it
    task automatic wait_for_halt(input logic [31:0] halt_pc);
        int settled;
        settled = 0;
        while (settled < 8) begin
            @(negedge clk);
            if (imem_addr >= halt_pc && imem_addr <= halt_pc + 32'd8) begin
                settled++;
            end else begin
                settled = 0;
            end
        end
    endtask

    task automatic run_program(input int p);
        @(negedge clk);
        reset = 1'b1;
        for (int i = 0; i < 256; i++) begin
            imem[i] = (i < prog_len[p]) ? progs[p][i] : nop_instr;
            dmem[i] = fill_word(i);
        end
        exp_addr_q.delete();
        exp_data_q.delete();
        run_reference(p);
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        assert (imem_addr == '0) else begin
            $display("[FAIL] imem_addr: expected %h, got %h", 32'h0, imem_addr);
            value_errors++;
        end
        assert (!dmem_req.read && !dmem_req.write) else begin
            $display("A data strobe is high right after reset in program %0d", p);
            other_errors++;
        end
        wait_for_halt((prog_len[p] - 1) * 4);
        assert (exp_addr_q.size() == 0) else begin
            $display("Program %0d is missing %0d stores of the reference trace",
                     p, exp_addr_q.size());
            trace_errors += exp_addr_q.size();
        end
    endtask

    task automatic print_counts();
        $display("Errors: %0d wrong values, %0d missing or extra stores, %0d other",
                 value_errors, trace_errors, other_errors);
    endtask

    task automatic run_watchdog(input int cycles);
        repeat (cycles) @(posedge clk);
        $display("Timeout after %0d cycles, a program never reached its self-loop", cycles);
        print_counts();
        $display("Simulation failed");
        $finish;
    endtask

    initial begin
        reset        = 1'b1;
        value_errors = 0;
        trace_errors = 0;
        other_errors = 0;
        lfsr         = 16'd26376;
        for (int i = 0; i < 256; i++) begin
            imem[i] = nop_instr;
            dmem[i] = fill_word(i);
        end
        build_programs();
        cycle_limit = 200;
        for (int p = 0; p < $size(prog_len); p++) begin
            cycle_limit += 4 * prog_len[p];
        end
        fork
            run_watchdog(cycle_limit);
        join_none
        for (int p = 0; p < $size(prog_len); p++) begin
            run_program(p);
        end
        print_counts();
        if (value_errors + trace_errors + other_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== testbench/core_tb_sva.sv ====
`timescale 1ns/10ps

module core_tb_sva
    import core_pkg::*;
(
    input logic            clk,
    input logic            reset,
    input logic            stall,
    input logic            flush,
    input logic [xlen-1:0] pc,
    input if_id_t          if_id,
    input dmem_req_t       dmem_req
);

    // First reset edge clears EX/MEM
    no_write_in_reset: assert property (@(posedge clk) reset |=> !dmem_req.write)
        else $error("Data write strobe high while reset is asserted");

    // Flush must win over a held IF/ID
    flush_bubbles_if_id: assert property (@(posedge clk) disable iff (reset)
        flush |=> !if_id.valid)
        else $error("IF/ID still holds a valid instruction after a branch flush");

    pc_held_on_stall: assert property (@(posedge clk) disable iff (reset)
        stall |=> $stable(pc))
        else $error("PC moved during a load-use stall");

    read_write_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(dmem_req.read && dmem_req.write))
        else $error("Data read and write strobes are high together");

endmodule

bind riscv_core core_tb_sva sva0 (
    .clk      (clk),
    .reset    (reset),
    .stall    (stall),
    .flush    (flush),
    .pc       (pc),
    .if_id    (if_id_q),
    .dmem_req (dmem_req)
);

// ==== verilog.f ====
src/core_pkg.sv
src/pipe_reg.sv
src/decode_unit.sv
src/register_file.sv
src/alu.sv
src/execute_stage.sv
src/hazard_unit.sv
src/riscv_core.sv
testbench/core_tb_sva.sv
testbench/core_tb.sv
